// ==== logic/scope_settings.svh ====
`ifndef SCOPE_SETTINGS_SVH
`define SCOPE_SETTINGS_SVH

// 640x480 at one pixel per clk
`define SCOPE_H_ACTIVE 640
`define SCOPE_H_FRONT  16
`define SCOPE_H_SYNC   96
`define SCOPE_H_BACK   48
`define SCOPE_V_ACTIVE 480
`define SCOPE_V_FRONT  10
`define SCOPE_V_SYNC   2
`define SCOPE_V_BACK   33

`define SCOPE_H_TOTAL (`SCOPE_H_ACTIVE + `SCOPE_H_FRONT + `SCOPE_H_SYNC + `SCOPE_H_BACK)
`define SCOPE_V_TOTAL (`SCOPE_V_ACTIVE + `SCOPE_V_FRONT + `SCOPE_V_SYNC + `SCOPE_V_BACK)

// Trace geometry
`define SCOPE_MID_ROW 240 // Zero line of both traces
`define SCOPE_SHIFT   8   // Sample to row offset

// One sample per visible column
`define SCOPE_BUF_DEPTH 640
`define SCOPE_ADDR_W    10

`endif

// ==== logic/scope_pkg.sv ====
package scope_pkg;

  // One stereo codec sample
  typedef struct packed {
    logic signed [15:0] left;  // Left channel, trigger source
    logic signed [15:0] right; // Right channel
  } audio_sample_t;

  // Raster position from the timing generator
  typedef struct packed {
    logic [9:0] x;      // Column, 0..799
    logic [9:0] y;      // Line, 0..524
    logic       active; // Inside 640x480 area
  } pixel_pos_t;

  // All active low
  typedef struct packed {
    logic hs;      // Horizontal sync
    logic vs;      // Vertical sync
    logic blank_n; // Low outside visible area
  } vga_sync_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  localparam rgb_t trace_left_c  = '{r: 8'h00, g: 8'hff, b: 8'h00}; // Green
  localparam rgb_t trace_right_c = '{r: 8'hff, g: 8'h00, b: 8'h00}; // Red
  localparam rgb_t axis_c        = '{r: 8'h00, g: 8'h00, b: 8'h80}; // Dim blue
  localparam rgb_t black_c       = '{r: 8'h00, g: 8'h00, b: 8'h00};

endpackage

// ==== logic/vga_timing.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module vga_timing (
  input  logic                  clk,
  input  logic                  rst_n,
  output scope_pkg::pixel_pos_t pos,          // Registered counters and active flag
  output scope_pkg::vga_sync_t  sync,         // Registered sync and blank
  output logic                  vblank_start  // Pulse at x 0, y 480
);
  import scope_pkg::*;

  localparam logic [9:0] h_last   = 10'(`SCOPE_H_TOTAL - 1);
  localparam logic [9:0] v_last   = 10'(`SCOPE_V_TOTAL - 1);
  localparam logic [9:0] h_active = 10'(`SCOPE_H_ACTIVE);
  localparam logic [9:0] v_active = 10'(`SCOPE_V_ACTIVE);
  localparam logic [9:0] hs_start = 10'(`SCOPE_H_ACTIVE + `SCOPE_H_FRONT);
  localparam logic [9:0] hs_end   = 10'(`SCOPE_H_ACTIVE + `SCOPE_H_FRONT + `SCOPE_H_SYNC);
  localparam logic [9:0] vs_start = 10'(`SCOPE_V_ACTIVE + `SCOPE_V_FRONT);
  localparam logic [9:0] vs_end   = 10'(`SCOPE_V_ACTIVE + `SCOPE_V_FRONT + `SCOPE_V_SYNC);

  logic [9:0] x_nxt;      // Counter values for next cycle
  logic [9:0] y_nxt;
  logic       h_end;      // Last pixel of a line
  logic       v_end;      // Last line of a frame
  logic       active_nxt;

  assign h_end = (pos.x == h_last);
  assign v_end = (pos.y == v_last);

  always_comb begin
    x_nxt = h_end ? 10'd0 : pos.x + 10'd1;
    y_nxt = pos.y;                               // Line only moves at end of line
    if (h_end) begin
      y_nxt = v_end ? 10'd0 : pos.y + 10'd1;
    end
  end

  assign active_nxt = (x_nxt < h_active) && (y_nxt < v_active);

  // Decode from next counts so all outputs line up with pos
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pos          <= '{x: 10'd0, y: 10'd0, active: 1'b1}; // Sits at first pixel
      sync         <= '{hs: 1'b1, vs: 1'b1, blank_n: 1'b1};
      vblank_start <= 1'b0;
    end else begin
      pos.x        <= x_nxt;
      pos.y        <= y_nxt;
      pos.active   <= active_nxt;
      sync.hs      <= !((x_nxt >= hs_start) && (x_nxt < hs_end)); // Low in sync pulse
      sync.vs      <= !((y_nxt >= vs_start) && (y_nxt < vs_end));
      sync.blank_n <= active_nxt;
      vblank_start <= (x_nxt == 10'd0) && (y_nxt == v_active); // First blank line
    end
  end

endmodule

// ==== logic/sample_capture.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module sample_capture (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           sample_valid, // One-cycle strobe
  input  scope_pkg::audio_sample_t       sample,
  input  logic                           vblank_start, // Arms capture
  input  logic                           line_zero,    // Frame start, disarms
  output logic                           wr_en,
  output logic [`SCOPE_ADDR_W-1:0]       wr_addr,
  output scope_pkg::audio_sample_t       wr_data
);
  import scope_pkg::*;

  localparam logic [`SCOPE_ADDR_W-1:0] last_idx = `SCOPE_ADDR_W'(`SCOPE_BUF_DEPTH - 1);

  logic                      armed;     // Waiting for or filling a capture
  logic                      triggered; // Crossing seen this capture
  logic [`SCOPE_ADDR_W-1:0]  wr_idx;    // Next buffer address
  logic signed [15:0]        prev_left; // Trigger history
  logic                      crossing;  // Rising zero crossing on left
  logic                      write_hit; // Strobe is stored this cycle

  // Negative to zero or above
  assign crossing  = (prev_left < 16'sd0) && (sample.left >= 16'sd0);

  assign write_hit = armed && sample_valid && !vblank_start && !line_zero &&
                     (triggered || crossing);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      armed     <= 1'b0;
      triggered <= 1'b0;
      wr_idx    <= '0;
      prev_left <= 16'sd0;
      wr_en     <= 1'b0;
    end else begin
      wr_en <= write_hit;                   // Write lands one cycle after strobe
      if (sample_valid) begin
        prev_left <= sample.left;           // Updated armed or not
      end
      if (vblank_start) begin
        armed     <= 1'b1;
        triggered <= 1'b0;
        wr_idx    <= '0;
      end else if (line_zero) begin
        armed <= 1'b0;                      // Display starts, freeze buffer
      end else if (write_hit) begin
        triggered <= 1'b1;
        if (wr_idx == last_idx) begin
          armed <= 1'b0;                    // Screen width filled
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
    end
  end

  // Address and data only qualified by wr_en
  always_ff @(posedge clk) begin
    if (write_hit) begin
      wr_addr <= wr_idx;
      wr_data <= sample;
    end
  end

endmodule

// ==== logic/trace_buffer.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module trace_buffer (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [`SCOPE_ADDR_W-1:0] wr_addr,
  input  scope_pkg::audio_sample_t wr_data,
  input  logic [`SCOPE_ADDR_W-1:0] rd_addr, // Column from renderer
  output scope_pkg::audio_sample_t rd_data  // Valid one cycle after rd_addr
);
  import scope_pkg::*;

  audio_sample_t mem [`SCOPE_BUF_DEPTH]; // One entry per column

  // Capture port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read for block RAM
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== logic/trace_renderer.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module trace_renderer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  scope_pkg::pixel_pos_t    pos,
  input  scope_pkg::vga_sync_t     sync,
  input  logic [1:0]               channel_enable, // Bit 0 left, bit 1 right
  output logic [`SCOPE_ADDR_W-1:0] rd_addr,
  input  scope_pkg::audio_sample_t rd_data,
  output scope_pkg::rgb_t          color,
  output scope_pkg::vga_sync_t     sync_out
);
  import scope_pkg::*;

  pixel_pos_t pos_q;    // Stage 1 position, aligned with rd_data
  vga_sync_t  sync_q;   // Stage 1 sync
  logic [9:0] row_left; // Screen row of each trace in this column
  logic [9:0] row_right;
  rgb_t       color_nxt;

  // Sample to screen row, positive values go up
  function automatic logic [9:0] trace_row(input logic signed [15:0] s);
    logic signed [15:0] offset;
    offset = s >>> `SCOPE_SHIFT;              // Range -128..127
    return 10'(`SCOPE_MID_ROW - offset);
  endfunction

  assign rd_addr = pos.x;                     // Buffer read in stage 1

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pos_q  <= '{x: 10'd0, y: 10'd0, active: 1'b0};
      sync_q <= '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0};
    end else begin
      pos_q  <= pos;
      sync_q <= sync;
    end
  end

  assign row_left  = trace_row(rd_data.left);
  assign row_right = trace_row(rd_data.right);

  // Left over right over axis
  always_comb begin
    if (!pos_q.active) begin
      color_nxt = black_c;
    end else if (channel_enable[0] && (row_left == pos_q.y)) begin
      color_nxt = trace_left_c;
    end else if (channel_enable[1] && (row_right == pos_q.y)) begin
      color_nxt = trace_right_c;
    end else if (pos_q.y == 10'(`SCOPE_MID_ROW)) begin
      color_nxt = axis_c;
    end else begin
      color_nxt = black_c;
    end
  end

  // Stage 2 output registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      color    <= black_c;
      sync_out <= '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0}; // Idle, blanked
    end else begin
      color    <= color_nxt;
      sync_out <= sync_q;
    end
  end

endmodule

// ==== logic/audio_scope.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module audio_scope (
  input  logic                     clk,            // Pixel clock
  input  logic                     rst_n,
  input  logic                     sample_valid,   // Strobe in clk domain
  input  scope_pkg::audio_sample_t sample,
  input  logic [1:0]               channel_enable, // Bit 0 left, bit 1 right
  output scope_pkg::rgb_t          vga_color,
  output scope_pkg::vga_sync_t     vga_sync
);
  import scope_pkg::*;

  pixel_pos_t                 pos;
  vga_sync_t                  sync;
  logic                       vblank_start;
  logic                       line_zero;   // First pixel of first active line
  logic                       wr_en;
  logic [`SCOPE_ADDR_W-1:0]   wr_addr;
  audio_sample_t              wr_data;
  logic [`SCOPE_ADDR_W-1:0]   rd_addr;
  audio_sample_t              rd_data;

  assign line_zero = (pos.x == 10'd0) && (pos.y == 10'd0);

  vga_timing u_timing (
    .clk          (clk),
    .rst_n        (rst_n),
    .pos          (pos),
    .sync         (sync),
    .vblank_start (vblank_start)
  );

  sample_capture u_capture (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample       (sample),
    .vblank_start (vblank_start),
    .line_zero    (line_zero),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data)
  );

  trace_buffer u_buffer (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  trace_renderer u_renderer (
    .clk            (clk),
    .rst_n          (rst_n),
    .pos            (pos),
    .sync           (sync),
    .channel_enable (channel_enable),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data),
    .color          (vga_color),
    .sync_out       (vga_sync)
  );

endmodule

// ==== testbench/audio_scope_tb.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module audio_scope_tb;
  import scope_pkg::*;

  localparam int h_total        = `SCOPE_H_TOTAL;
  localparam int v_total        = `SCOPE_V_TOTAL;
  localparam int run_frames     = 4;
  localparam int timeout_cycles = 5 * h_total * v_total; // One spare frame

  logic          clk;
  logic          rst_n;
  logic          sample_valid;
  audio_sample_t sample;
  logic [1:0]    channel_enable;
  rgb_t          vga_color;
  vga_sync_t     vga_sync;

  logic [15:0]        lfsr;                // Stimulus generator
  int                 mode;                // 0 ramp, 1 random, 2 left held negative
  int                 ramp, ramp_dir;
  int                 mx, my;              // Model raster counters
  int                 frames_done, cycles;
  int                 trig_frames, stale_frames;
  logic               armed, trig;         // Model capture state
  int                 idx;
  logic signed [15:0] prev_left;
  audio_sample_t      mem_m [`SCOPE_BUF_DEPTH];
  logic               known [`SCOPE_BUF_DEPTH]; // Entry written since reset
  logic               pend_v;              // Write landing at next edge
  int                 pend_a;
  audio_sample_t      pend_d;
  int                 q_x, q_y;            // Model stage 1
  vga_sync_t          q_sync;
  audio_sample_t      rd_q;
  logic               rd_known;
  rgb_t               exp_color;           // Model stage 2 result checked at next falling edge
  vga_sync_t          exp_sync;
  logic               exp_color_ok;
  logic [1:0]         exp_en;
  int                 exp_x, exp_y;
  logic               covered;

  audio_scope u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_valid   (sample_valid),
    .sample         (sample),
    .channel_enable (channel_enable),
    .vga_color      (vga_color),
    .vga_sync       (vga_sync)
  );

  always #5 clk = ~clk;

  // Taps 16, 14, 13, 11
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic int row_of(input logic signed [15:0] s);
    return `SCOPE_MID_ROW - int'(s >>> `SCOPE_SHIFT); // Positive goes up
  endfunction

  function automatic vga_sync_t sync_of(input int x, input int y);
    vga_sync_t s;
    s.hs      = !(x >= 656 && x < 752);      // 96 pixel pulse after the front porch
    s.vs      = !(y >= 490 && y < 492);      // 2 line pulse after the front porch
    s.blank_n = (x < 640) && (y < 480);
    return s;
  endfunction

  function automatic rgb_t pixel_color(input int y, input logic active,
                                       input audio_sample_t s, input logic [1:0] en);
    if (!active) return black_c;
    if (en[0] && row_of(s.left) == y) return trace_left_c;   // Left wins ties
    if (en[1] && row_of(s.right) == y) return trace_right_c;
    if (y == `SCOPE_MID_ROW) return axis_c;
    return black_c;
  endfunction

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got %h expected %h at x %0d y %0d", name, got, exp, exp_x, exp_y);
      abort_run();
    end
  endtask

  task automatic check_outputs();
    check_field("vga_sync", {29'd0, vga_sync}, {29'd0, exp_sync});
    if (exp_color_ok) check_field("vga_color", {8'd0, vga_color}, {8'd0, exp_color});
    assert ((exp_en[0] || vga_color != trace_left_c) &&
            (exp_en[1] || vga_color != trace_right_c)) else begin
      $display("Disabled channel drawn at x %0d y %0d", exp_x, exp_y);
      abort_run();
    end
  endtask

  // Mode and enables move at the start of vertical blank
  task automatic set_frame_controls();
    if (mx == 0 && my == `SCOPE_V_ACTIVE) begin
      mode = (frames_done == 0) ? 0 : (frames_done == 2) ? 2 : 1;
      case (frames_done)
        0:       channel_enable = 2'b11;
        1:       channel_enable = 2'b10; // Right only
        2:       channel_enable = 2'b01; // Left only
        default: channel_enable = 2'b11;
      endcase
    end
  endtask

  task automatic drive_inputs();
    logic [15:0] bits;
    sample_valid = (rand_bits(3) == 16'd0);
    if (sample_valid) begin
      case (mode)
        0: begin
          ramp = ramp + ramp_dir * (128 + int'(rand_bits(9)));
          if (ramp > 24000) ramp_dir = -1;
          else if (ramp < -24000) ramp_dir = 1;
          sample.left  = 16'(ramp);
          sample.right = 16'(ramp >>> 1);    // Meets left near zero
        end
        1: begin
          sample.left  = rand_bits(16);
          sample.right = rand_bits(16);
        end
        default: begin
          bits         = rand_bits(15);
          sample.left  = {1'b1, bits[14:0]}; // No crossing possible
          sample.right = rand_bits(16);
        end
      endcase
    end
  endtask

  // What the DUT does at the coming rising edge
  task automatic model_edge();
    logic hit, vbl, lz;
    exp_color    = pixel_color(q_y, q_sync.blank_n, rd_q, channel_enable);
    exp_color_ok = !q_sync.blank_n || rd_known;
    exp_sync     = q_sync;
    exp_en       = channel_enable;
    exp_x        = q_x;
    exp_y        = q_y;
    q_x          = mx;
    q_y          = my;
    q_sync       = sync_of(mx, my);
    if (mx < `SCOPE_BUF_DEPTH) begin
      rd_q     = mem_m[mx];                  // Read before the landing write
      rd_known = known[mx];
    end
    if (pend_v) begin
      mem_m[pend_a] = pend_d;
      known[pend_a] = 1'b1;
    end
    vbl    = (mx == 0 && my == `SCOPE_V_ACTIVE);
    lz     = (mx == 0 && my == 0);
    hit    = armed && sample_valid && !vbl && !lz &&
             (trig || (prev_left < 0 && sample.left >= 0));
    pend_v = hit;
    pend_a = idx;
    pend_d = sample;
    if (sample_valid) prev_left = sample.left;
    if (lz && frames_done > 0) begin
      if (trig) trig_frames++;
      else stale_frames++;
    end
    if (vbl) begin
      armed = 1'b1;
      trig  = 1'b0;
      idx   = 0;
    end else if (lz) begin
      armed = 1'b0;
    end else if (hit) begin
      trig = 1'b1;
      if (idx == `SCOPE_BUF_DEPTH - 1) armed = 1'b0;
      else idx++;
    end
    mx++;
    if (mx == h_total) begin
      mx = 0;
      my++;
      if (my == v_total) begin
        my = 0;
        frames_done++;
      end
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles with %0d of %0d frames done",
               cycles, frames_done, run_frames);
      abort_run();
    end
  end

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    sample_valid   = 1'b0;
    sample         = '0;
    channel_enable = 2'b01;
    lfsr           = 16'd46494;
    mode           = 1;
    ramp           = 0;
    ramp_dir       = 1;
    {mx, my, frames_done, cycles, trig_frames, stale_frames, idx} = '0;
    {armed, trig, pend_v, rd_known} = '0;
    prev_left      = 16'sd0;
    {pend_a, q_x, q_y, exp_x, exp_y} = '0;
    pend_d         = '0;
    rd_q           = '0;
    q_sync         = '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0}; // Renderer reset state
    exp_sync       = q_sync;
    exp_color      = black_c;
    exp_color_ok   = 1'b1;
    exp_en         = channel_enable;
    for (int i = 0; i < `SCOPE_BUF_DEPTH; i++) begin
      known[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;                            // Counters hold x 0 and y 0 this cycle
    while (frames_done < run_frames) begin
      check_outputs();
      set_frame_controls();
      drive_inputs();
      model_edge();
      @(negedge clk);
    end
    covered = (trig_frames >= 2) && (stale_frames >= 1);
    assert (covered) else $display("Stimulus missed a triggered or an untriggered frame");
    if (covered) begin
      $display("Done: no errors");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// ==== audio_scope.f ====
+incdir+logic
logic/scope_pkg.sv
logic/vga_timing.sv
logic/sample_capture.sv
logic/trace_buffer.sv
logic/trace_renderer.sv
logic/audio_scope.sv
testbench/audio_scope_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the audio scope testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f audio_scope.f \
    --top-module audio_scope_tb -Mdir obj_dir -o audio_scope_sim; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/audio_scope_sim 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
echo "Pass line missing from simulation output"
exit 1
